// File: compile.f
verilog/fme7_pkg.sv
verilog/fme7_bank_if.sv
verilog/fme7_cmd_decode.sv
verilog/fme7_bank_regs.sv
verilog/fme7_irq_counter.sv
verilog/fme7_addr_map.sv
verilog/fme7_mapper.sv
tb/tb_clock.sv
tb/tb_fme7.sv

// File: Makefile
TOP = tb_fme7
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f verilog/*.sv tb/*.sv
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

lint:
	verilator --lint-only -Wall --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: tb/tb_fme7.sv
// Self-checking FME-7 testbench; inputs change on falling edges, LCG stimulus with a fixed seed
`timescale 1ns/1ns

module tb_fme7;

	localparam int CLK_NS = 4;
	localparam int RESET_CYCLES = 10;
	localparam int TEST_CYCLES = 3000;
	localparam logic [31:0] SEED = 32'h1c48_0d9d;

	logic                        clk;
	logic                        rst_n;
	logic                        ce;
	logic [fme7_pkg::CPU_AW-1:0] prg_ain;
	logic                        prg_write;
	logic [7:0]                  prg_din;
	logic [fme7_pkg::PPU_AW-1:0] chr_ain;
	logic [fme7_pkg::MEM_AW-1:0] prg_aout;
	logic                        prg_allow;
	logic [fme7_pkg::MEM_AW-1:0] chr_aout;
	logic                        vram_a10;
	logic                        vram_ce;
	logic                        irq;

	logic [31:0] lcg_state;
	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	int test_err0;

	// Reference copies of the bank registers
	logic [7:0] chr_model [8];
	logic [4:0] prg_model [4];
	logic       ram_en_model;
	logic       ram_sel_model;
	logic [1:0] mir_model;

	tb_clock i_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	fme7_mapper i_fme7_mapper (
		.clk       (clk),
		.rst_n     (rst_n),
		.ce        (ce),
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.prg_din   (prg_din),
		.chr_ain   (chr_ain),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.chr_aout  (chr_aout),
		.vram_a10  (vram_a10),
		.vram_ce   (vram_ce),
		.irq       (irq)
	);

	a_vram_ce : assert property (@(posedge clk) disable iff (!rst_n) vram_ce == chr_ain[13])
		else begin
			$display("[FAIL] vram_ce expected 0x%h actual 0x%h",
				$sampled(chr_ain[13]), $sampled(vram_ce));
			errors++;
		end

	// irq may only move on a CPU cycle
	a_irq_on_ce : assert property (@(posedge clk) disable iff (!rst_n)
		$changed(irq) |-> $past(ce))
		else begin
			$display("irq changed after a clock edge without ce");
			errors++;
		end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// About three cycles in four
	function automatic logic busy_ce();
		logic [31:0] r;
		r = next_rand();
		return r[17:16] != 2'b00;
	endfunction

	function automatic logic [21:0] exp_prg_aout(input logic [15:0] a);
		logic [4:0] b;
		logic [3:0] tag;
		if (a >= 16'hE000)
			b = fme7_pkg::PRG_FIXED_BANK;
		else if (a >= 16'hC000)
			b = prg_model[3];
		else if (a >= 16'hA000)
			b = prg_model[2];
		else if (a >= 16'h8000)
			b = prg_model[1];
		else if (a >= 16'h6000)
			b = prg_model[0];
		else
			b = 5'd0;
		tag = (a < 16'h8000 && ram_sel_model) ? fme7_pkg::PRG_RAM_TAG : fme7_pkg::PRG_ROM_TAG;
		return {tag, b, a[12:0]};
	endfunction

	function automatic logic exp_prg_allow(input logic [15:0] a, input logic wr);
		return (a < 16'h8000 && ram_sel_model) ? ram_en_model : !wr;
	endfunction

	function automatic logic exp_vram_a10(input logic [13:0] c);
		case (mir_model)
			2'd0:    return c[10];
			2'd1:    return c[11];
			default: return mir_model[0]; // One-screen page
		endcase
	endfunction

	// Complement of the modelled register behind a data index
	function automatic logic [7:0] flipped_reg(input logic [3:0] idx);
		if (idx < fme7_pkg::CMD_PRG0)
			return ~chr_model[idx[2:0]];
		else if (idx == fme7_pkg::CMD_PRG0)
			return {~ram_en_model, ~ram_sel_model, 1'b0, ~prg_model[0]};
		else if (idx < fme7_pkg::CMD_MIRROR)
			return {3'b000, ~prg_model[idx[1:0]]};
		else
			return {6'd0, ~mir_model};
	endfunction

	task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			$display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
			errors++;
		end
	endtask

	task automatic start_test();
		test_err0 = errors;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != test_err0) begin
			tests_failed++;
			$display("Test %0d %s: failed with %0d errors", tests_run, name, errors - test_err0);
		end else begin
			$display("Test %0d %s: ok", tests_run, name);
		end
	endtask

	// Called just after a falling edge, returns one cycle later
	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		prg_ain = addr;
		prg_din = data;
		prg_write = 1'b1;
		ce = 1'b1;
		@(negedge clk);
		prg_write = 1'b0;
		ce = 1'b0;
	endtask

	task automatic idle_cycle();
		prg_write = 1'b0;
		ce = busy_ce();
		@(negedge clk);
	endtask

	task automatic write_reg(input logic [3:0] idx, input logic [7:0] data);
		logic [31:0] r;
		r = next_rand();
		cpu_write({3'b100, r[12:0]}, {4'h0, idx});
		idle_cycle();
		cpu_write({3'b101, r[28:16]}, data);
		if (idx < fme7_pkg::CMD_PRG0) begin
			chr_model[idx[2:0]] = data;
		end else if (idx < fme7_pkg::CMD_MIRROR) begin
			prg_model[idx[1:0]] = data[4:0];
			if (idx == fme7_pkg::CMD_PRG0) begin
				ram_en_model = data[7];
				ram_sel_model = data[6];
			end
		end else if (idx == fme7_pkg::CMD_MIRROR) begin
			mir_model = data[1:0];
		end
	endtask

	// Data byte presented at $A000-$BFFF with ce held low
	task automatic stalled_write(input logic [7:0] data);
		logic [31:0] r;
		r = next_rand();
		prg_ain = {3'b101, r[12:0]};
		prg_din = data;
		prg_write = 1'b1;
		ce = 1'b0;
		@(negedge clk);
		prg_write = 1'b0;
	endtask

	task automatic lookup(input logic [15:0] pa, input logic pw, input logic [13:0] ca);
		prg_ain = pa;
		prg_write = pw;
		chr_ain = ca;
		ce = pw ? 1'b0 : busy_ce(); // Probing prg_write must not become a register write
		@(negedge clk);
		expect_eq("prg_aout", 32'(exp_prg_aout(pa)), 32'(prg_aout));
		expect_eq("prg_allow", 32'(exp_prg_allow(pa, pw)), 32'(prg_allow));
		expect_eq("chr_aout", 32'({fme7_pkg::CHR_TAG, chr_model[ca[12:10]], ca[9:0]}),
			32'(chr_aout));
		expect_eq("vram_a10", 32'(exp_vram_a10(ca)), 32'(vram_a10));
		expect_eq("vram_ce", 32'(ca[13]), 32'(vram_ce));
	endtask

	// Every PRG window and every CHR slot once
	task automatic sweep_outputs(input logic pw);
		logic [31:0] r;
		for (int i = 0; i < 8; i++) begin
			r = next_rand();
			lookup({i[2:0], r[12:0]}, pw, {r[13], i[2:0], r[25:16]});
		end
		prg_write = 1'b0;
		expect_eq("irq", 32'h0, 32'(irq));
	endtask

	task automatic irq_timing(input int n);
		int ce_edges;
		int cyc;
		logic exp_irq;
		write_reg(fme7_pkg::CMD_IRQ_CTRL, 8'h00);
		write_reg(fme7_pkg::CMD_IRQ_LO, n[7:0]);
		write_reg(fme7_pkg::CMD_IRQ_HI, 8'h00);
		write_reg(fme7_pkg::CMD_IRQ_CTRL, 8'h81); // Countdown and trigger
		ce_edges = 0;
		cyc = 0;
		while (ce_edges < n + 6 && cyc < 200) begin
			ce = busy_ce();
			@(negedge clk);
			if (ce)
				ce_edges++;
			exp_irq = (ce_edges >= n + 1);
			expect_eq("irq", 32'(exp_irq), 32'(irq));
			cyc++;
		end
		cpu_write(16'h8000, {4'h0, fme7_pkg::CMD_IRQ_CTRL});
		idle_cycle();
		expect_eq("irq", 32'h1, 32'(irq));
		cpu_write(16'hA000, 8'h80); // Trigger off drops irq at this edge
		expect_eq("irq", 32'h0, 32'(irq));
	endtask

	initial begin
		#(CLK_NS * (RESET_CYCLES + TEST_CYCLES));
		$display("Timeout: the tests did not finish within %0d cycles", TEST_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		logic [31:0] r;
		ce = 1'b0;
		prg_ain = '0;
		prg_write = 1'b0;
		prg_din = '0;
		chr_ain = '0;
		lcg_state = SEED;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int i = 0; i < 8; i++)
			chr_model[i] = 8'h00;
		for (int i = 0; i < 4; i++)
			prg_model[i] = 5'h00;
		ram_en_model = 1'b0;
		ram_sel_model = 1'b0;
		mir_model = 2'd0;
		wait (rst_n);
		@(negedge clk);

		start_test();
		expect_eq("irq", 32'h0, 32'(irq));
		lookup(16'h8123, 1'b0, 14'h0000);
		lookup(16'hE000, 1'b0, 14'h0400);
		sweep_outputs(1'b0);
		finish_test("reset");

		start_test();
		for (int i = 0; i < 8; i++) begin
			r = next_rand();
			write_reg(i[3:0], r[23:16]);
		end
		sweep_outputs(1'b0);
		sweep_outputs(1'b0);
		finish_test("chr_banks");

		start_test();
		for (int k = 0; k < 4; k++) begin
			r = next_rand();
			write_reg(fme7_pkg::CMD_PRG0, {k[1], k[0], r[21:16]});
			for (int i = 1; i < 4; i++) begin
				r = next_rand();
				write_reg(fme7_pkg::CMD_PRG0 + i[3:0], r[23:16]);
			end
			sweep_outputs(1'b0);
			sweep_outputs(1'b1);
		end
		finish_test("prg_banks");

		start_test();
		for (int m = 0; m < 4; m++) begin
			r = next_rand();
			write_reg(fme7_pkg::CMD_MIRROR, {r[23:18], m[1:0]});
			sweep_outputs(1'b0);
		end
		finish_test("mirroring");

		start_test();
		irq_timing(3);
		irq_timing(20);
		r = next_rand();
		irq_timing(3 + int'(r[23:16]) % 18);
		write_reg(fme7_pkg::CMD_IRQ_CTRL, 8'h00);
		write_reg(fme7_pkg::CMD_IRQ_LO, 8'h02);
		write_reg(fme7_pkg::CMD_IRQ_HI, 8'h00);
		write_reg(fme7_pkg::CMD_IRQ_CTRL, 8'h80); // Counting, trigger off
		repeat (30) begin
			idle_cycle();
			expect_eq("irq", 32'h0, 32'(irq));
		end
		finish_test("irq_timing");

		start_test();
		write_reg(fme7_pkg::CMD_IRQ_CTRL, 8'h00);
		write_reg(fme7_pkg::CMD_IRQ_LO, 8'h00);
		write_reg(fme7_pkg::CMD_IRQ_HI, 8'h00);
		foreach (chr_model[i]) begin
			cpu_write(16'h8000, {4'h0, i[3:0] + 4'd6}); // Indices 6 to 13
			stalled_write(i == 7 ? 8'h81 : flipped_reg(i[3:0] + 4'd6));
			sweep_outputs(1'b0);
		end
		finish_test("ce_gating");

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: tb/tb_clock.sv
// Testbench clock and reset; fixed 4 ns period, rst_n released on a falling edge after 10 cycles
`timescale 1ns/1ns

module tb_clock (
	output logic clk,
	output logic rst_n
);

	localparam int HALF_PERIOD_NS = 2;
	localparam int RESET_CYCLES = 10;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD_NS clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk); // Same edge the stimulus uses
		rst_n = 1'b1;
	end

endmodule

// File: verilog/fme7_mapper.sv
// FME-7 mapper top; bank switching and IRQ only, outputs are always driven with no enable gating
`timescale 1ns/1ns

module fme7_mapper (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        ce,        // CPU cycle enable
	input  logic [fme7_pkg::CPU_AW-1:0] prg_ain,
	input  logic                        prg_write,
	input  logic [7:0]                  prg_din,
	input  logic [fme7_pkg::PPU_AW-1:0] chr_ain,
	output logic [fme7_pkg::MEM_AW-1:0] prg_aout,
	output logic                        prg_allow,
	output logic [fme7_pkg::MEM_AW-1:0] chr_aout,
	output logic                        vram_a10,
	output logic                        vram_ce,
	output logic                        irq
);

	logic                       wr_en;
	logic [fme7_pkg::CMD_W-1:0] wr_cmd;
	fme7_pkg::cmd_data_u        wr_data;

	fme7_bank_if bank_if ();

	fme7_cmd_decode i_cmd_decode (
		.clk       (clk),
		.rst_n     (rst_n),
		.ce        (ce),
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.prg_din   (prg_din),
		.wr_en     (wr_en),
		.wr_cmd    (wr_cmd),
		.wr_data   (wr_data)
	);

	fme7_bank_regs i_bank_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_en   (wr_en),
		.wr_cmd  (wr_cmd),
		.wr_data (wr_data),
		.bank    (bank_if.regs)
	);

	fme7_irq_counter i_irq_counter (
		.clk     (clk),
		.rst_n   (rst_n),
		.ce      (ce),
		.wr_en   (wr_en),
		.wr_cmd  (wr_cmd),
		.wr_data (wr_data),
		.irq     (irq)
	);

	fme7_addr_map i_addr_map (
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.chr_ain   (chr_ain),
		.bank      (bank_if.map),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.chr_aout  (chr_aout),
		.vram_a10  (vram_a10),
		.vram_ce   (vram_ce)
	);

endmodule

// File: verilog/fme7_addr_map.sv
// Combinational PRG/CHR address translation; addresses below $6000 get bank 0 and are not decoded
`timescale 1ns/1ns

module fme7_addr_map (
	input  logic [fme7_pkg::CPU_AW-1:0] prg_ain,
	input  logic                        prg_write,
	input  logic [fme7_pkg::PPU_AW-1:0] chr_ain,
	fme7_bank_if.map                    bank,
	output logic [fme7_pkg::MEM_AW-1:0] prg_aout,
	output logic                        prg_allow,
	output logic [fme7_pkg::MEM_AW-1:0] chr_aout,
	output logic                        vram_a10,
	output logic                        vram_ce
);

	logic [fme7_pkg::PRG_BANK_W-1:0] prg_sel;
	logic [fme7_pkg::CHR_BANK_W-1:0] chr_sel;
	logic [3:0]                      prg_tag;
	logic                            ram_cs;

	always_comb begin
		case (prg_ain[15:13])
			3'b011:  prg_sel = bank.prg_bank[0]; // $6000
			3'b100:  prg_sel = bank.prg_bank[1];
			3'b101:  prg_sel = bank.prg_bank[2];
			3'b110:  prg_sel = bank.prg_bank[3];
			3'b111:  prg_sel = fme7_pkg::PRG_FIXED_BANK;
			default: prg_sel = '0;
		endcase
	end

	// Only the $6000 window can reach PRG-RAM
	assign ram_cs = !prg_ain[15] && bank.ram_select;
	assign prg_tag = ram_cs ? fme7_pkg::PRG_RAM_TAG : fme7_pkg::PRG_ROM_TAG;
	assign prg_aout = {prg_tag, prg_sel, prg_ain[12:0]};
	assign prg_allow = ram_cs ? bank.ram_enable : !prg_write; // ROM is read-only

	assign chr_sel = bank.chr_bank[chr_ain[12:10]]; // 1 kB slots
	assign chr_aout = {fme7_pkg::CHR_TAG, chr_sel, chr_ain[9:0]};
	assign vram_ce = chr_ain[13]; // Nametables in console VRAM

	always_comb begin
		case (bank.mirror)
			fme7_pkg::MIR_VERTICAL:   vram_a10 = chr_ain[10];
			fme7_pkg::MIR_HORIZONTAL: vram_a10 = chr_ain[11];
			fme7_pkg::MIR_SCREEN_LO,
			fme7_pkg::MIR_SCREEN_HI:  vram_a10 = bank.mirror[0]; // One-screen page
			default:                  vram_a10 = chr_ain[10];
		endcase
	end

endmodule

// File: verilog/fme7_irq_counter.sv
// 16-bit CPU-cycle IRQ down-counter; counts only on ce, level IRQ held until trigger is cleared
`timescale 1ns/1ns

module fme7_irq_counter (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       ce,
	input  logic                       wr_en,
	input  logic [fme7_pkg::CMD_W-1:0] wr_cmd,
	input  fme7_pkg::cmd_data_u        wr_data,
	output logic                       irq
);

	localparam int CW = fme7_pkg::IRQ_CNT_W;

	logic          countdown;
	logic          trigger;
	logic [CW-1:0] count;
	logic [CW:0]   count_dec; // Top bit is the borrow out of zero
	logic          ctrl_wr;
	logic          lo_wr;
	logic          hi_wr;
	logic          trig_eff;

	assign ctrl_wr = wr_en && (wr_cmd == fme7_pkg::CMD_IRQ_CTRL);
	assign lo_wr = wr_en && (wr_cmd == fme7_pkg::CMD_IRQ_LO);
	assign hi_wr = wr_en && (wr_cmd == fme7_pkg::CMD_IRQ_HI);
	assign count_dec = {1'b0, count} - {{CW{1'b0}}, countdown};

	// A control write acts on irq in its own cycle
	assign trig_eff = ctrl_wr ? wr_data.irq.trigger : trigger;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			countdown <= 1'b0;
			trigger <= 1'b0;
			count <= '0;
			irq <= 1'b0;
		end else if (ce) begin
			count <= count_dec[CW-1:0]; // Wraps from 0 to FFFF
			if (lo_wr)
				count[7:0] <= wr_data.chr;
			if (hi_wr)
				count[CW-1:8] <= wr_data.chr;
			if (ctrl_wr) begin
				countdown <= wr_data.irq.countdown;
				trigger <= wr_data.irq.trigger;
			end

			if (!trig_eff)
				irq <= 1'b0;
			else if (count_dec[CW])
				irq <= 1'b1;
		end
	end

	a_irq_rise_armed : assert property (@(posedge clk) disable iff (!rst_n)
		$rose(irq) |-> $past(trig_eff && ce));

endmodule

// File: verilog/fme7_bank_regs.sv
// CHR/PRG bank, PRG-RAM and mirroring registers for indices 0..12; IRQ indices are ignored here
`timescale 1ns/1ns

module fme7_bank_regs (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       wr_en,
	input  logic [fme7_pkg::CMD_W-1:0] wr_cmd,
	input  fme7_pkg::cmd_data_u        wr_data,
	fme7_bank_if.regs                  bank
);

	logic [fme7_pkg::NUM_CHR_BANKS-1:0][fme7_pkg::CHR_BANK_W-1:0] chr_q;
	logic [fme7_pkg::NUM_PRG_BANKS-1:0][fme7_pkg::PRG_BANK_W-1:0] prg_q;
	logic ram_enable_q;
	logic ram_select_q;
	fme7_pkg::mirror_t mirror_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			chr_q <= '0;
			prg_q <= '0;
			ram_enable_q <= 1'b0;
			ram_select_q <= 1'b0;
			mirror_q <= fme7_pkg::MIR_VERTICAL;
		end else if (wr_en) begin
			if (wr_cmd < fme7_pkg::CMD_PRG0) begin
				chr_q[wr_cmd[2:0]] <= wr_data.chr;
			end else if (wr_cmd < fme7_pkg::CMD_MIRROR) begin
				prg_q[wr_cmd[1:0]] <= wr_data.prg.bank;
			end else if (wr_cmd == fme7_pkg::CMD_MIRROR) begin
				mirror_q <= wr_data.mir.mode;
			end

			// RAM control shares the byte with the $6000 bank
			if (wr_cmd == fme7_pkg::CMD_PRG0) begin
				ram_enable_q <= wr_data.prg.ram_enable;
				ram_select_q <= wr_data.prg.ram_select;
			end
		end
	end

	assign bank.chr_bank = chr_q;
	assign bank.prg_bank = prg_q;
	assign bank.ram_enable = ram_enable_q;
	assign bank.ram_select = ram_select_q;
	assign bank.mirror = mirror_q;

	// Mapping only moves on an accepted data write
	a_regs_hold : assert property (@(posedge clk)
		rst_n && !wr_en |=> $stable({chr_q, prg_q, ram_enable_q, ram_select_q, mirror_q}));

endmodule

// File: verilog/fme7_cmd_decode.sv
// CPU write decoder; writes are single-cycle strobes qualified by ce, no wait states or readback
`timescale 1ns/1ns

module fme7_cmd_decode (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          ce,
	input  logic [fme7_pkg::CPU_AW-1:0]   prg_ain,
	input  logic                          prg_write,
	input  logic [7:0]                    prg_din,
	output logic                          wr_en,
	output logic [fme7_pkg::CMD_W-1:0]    wr_cmd,
	output fme7_pkg::cmd_data_u           wr_data
);

	logic                       cpu_wr;
	logic                       idx_wr;
	logic [fme7_pkg::CMD_W-1:0] cmd_q;

	assign cpu_wr = ce && prg_write && prg_ain[15];
	assign idx_wr = cpu_wr && (prg_ain[14:13] == 2'd0); // $8000-$9FFF
	assign wr_en = cpu_wr && (prg_ain[14:13] == 2'd1);  // $A000-$BFFF

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cmd_q <= '0;
		end else if (idx_wr) begin
			cmd_q <= prg_din[fme7_pkg::CMD_W-1:0];
		end
	end

	assign wr_cmd = cmd_q;
	assign wr_data.chr = prg_din; // Raw byte, consumers pick their view

	a_wr_needs_ce : assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> ce && prg_write);

endmodule

// File: verilog/fme7_bank_if.sv
// Bank and mirroring state; written only by the register bank, read only by the address mapper
`timescale 1ns/1ns

interface fme7_bank_if;

	logic [fme7_pkg::NUM_CHR_BANKS-1:0][fme7_pkg::CHR_BANK_W-1:0] chr_bank;
	logic [fme7_pkg::NUM_PRG_BANKS-1:0][fme7_pkg::PRG_BANK_W-1:0] prg_bank;
	logic ram_enable; // PRG-RAM accesses allowed
	logic ram_select; // $6000 window maps to RAM
	fme7_pkg::mirror_t mirror;

	modport regs (
		output chr_bank,
		output prg_bank,
		output ram_enable,
		output ram_select,
		output mirror
	);

	modport map (
		input chr_bank,
		input prg_bank,
		input ram_enable,
		input ram_select,
		input mirror
	);

endinterface

// File: verilog/fme7_pkg.sv
// Shared FME-7 widths, command indices and data views; 22-bit memory map, no 5B sound registers
package fme7_pkg;

	localparam int CPU_AW = 16;
	localparam int PPU_AW = 14;
	localparam int MEM_AW = 22;
	localparam int CMD_W = 4;
	localparam int CHR_BANK_W = 8;
	localparam int PRG_BANK_W = 5;
	localparam int IRQ_CNT_W = 16;
	localparam int NUM_CHR_BANKS = 8;
	localparam int NUM_PRG_BANKS = 4;

	// Command indices 0..7 select the CHR banks
	localparam logic [CMD_W-1:0] CMD_PRG0 = 4'd8;
	localparam logic [CMD_W-1:0] CMD_MIRROR = 4'd12;
	localparam logic [CMD_W-1:0] CMD_IRQ_CTRL = 4'd13;
	localparam logic [CMD_W-1:0] CMD_IRQ_LO = 4'd14;
	localparam logic [CMD_W-1:0] CMD_IRQ_HI = 4'd15;

	localparam logic [PRG_BANK_W-1:0] PRG_FIXED_BANK = 5'h1F; // Last 8 kB at $E000
	localparam logic [3:0] PRG_RAM_TAG = 4'hF;
	localparam logic [3:0] PRG_ROM_TAG = 4'h0;
	localparam logic [3:0] CHR_TAG = 4'h8;

	typedef enum logic [1:0] {
		MIR_VERTICAL = 2'd0,
		MIR_HORIZONTAL = 2'd1,
		MIR_SCREEN_LO = 2'd2,
		MIR_SCREEN_HI = 2'd3
	} mirror_t;

	typedef struct packed {
		logic ram_enable;
		logic ram_select;
		logic spare;
		logic [PRG_BANK_W-1:0] bank;
	} prg_data_t;

	typedef struct packed {
		logic countdown;
		logic [5:0] spare;
		logic trigger;
	} irq_data_t;

	typedef struct packed {
		logic [5:0] spare;
		mirror_t mode;
	} mir_data_t;

	// One data byte, read according to the current command index
	typedef union packed {
		logic [CHR_BANK_W-1:0] chr;
		prg_data_t prg;
		irq_data_t irq;
		mir_data_t mir;
	} cmd_data_u;

endpackage
